// File: design/systolic_pkg.sv
package systolic_pkg;

    // one operand element, signed byte
    typedef logic signed [7:0] data_t;
    // accumulator and result word, four operand widths
    typedef logic signed [31:0] acc_t;
    // word address into operand or result memory
    typedef logic [7:0] addr_t;
    // register file index
    typedef logic [2:0] reg_addr_t;

    // controller sequence: fetch/feed, drain, write results
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        COMPUTING,
        WRITE_BACK
    } ctrl_state_t;

    // register map
    localparam reg_addr_t REG_A_BASE = 3'd0;
    localparam reg_addr_t REG_B_BASE = 3'd1;
    localparam reg_addr_t REG_C_BASE = 3'd2;
    localparam reg_addr_t REG_K_LEN  = 3'd3;
    // bit 0 go, write only, reads back 0
    localparam reg_addr_t REG_CTRL   = 3'd4;
    // bit 0 done, bit 1 busy
    localparam reg_addr_t REG_STATUS = 3'd7;

    // width of a row/column select, at least one bit
    function automatic int sel_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

// File: design/systolic_if.sv
`timescale 1ns/1ps

// configuration and handshake between register file and controller
interface cfg_if import systolic_pkg::*; #(
    parameter int ARRAY_SIZE = 4
) ();
    addr_t a_base;
    addr_t b_base;
    addr_t c_base;
    addr_t k_len;
    // single-cycle start request, already gated by busy and k_len
    logic  go;
    logic  done;
    logic  busy;
    // single-cycle end of run
    logic  finish;

    // result C[row][col] lands row-major from c_base
    function automatic addr_t c_addr(input int unsigned row, input int unsigned col);
        return addr_t'(c_base + row * ARRAY_SIZE + col);
    endfunction

    modport regs (output a_base, b_base, c_base, k_len, go, done, input busy, finish);
    modport ctrl (input a_base, b_base, c_base, k_len, go, output busy, finish, import c_addr);
endinterface

// operand feed and result read-out between controller and grid
interface feed_if import systolic_pkg::*; #(
    parameter int ARRAY_SIZE = 4
) ();
    localparam int SEL_W = sel_width(ARRAY_SIZE);

    // zero accumulators and skew stages
    logic                   clr;
    // one column/row pair enters the grid
    logic                   feed;
    data_t [ARRAY_SIZE-1:0] a_col;
    data_t [ARRAY_SIZE-1:0] b_row;
    logic [SEL_W-1:0]       sel_row;
    logic [SEL_W-1:0]       sel_col;
    acc_t                   result;

    modport ctrl (output clr, feed, a_col, b_row, sel_row, sel_col, input result);
    modport array (input clr, feed, a_col, b_row, sel_row, sel_col, output result);
endinterface

// File: design/config_regs.sv
`timescale 1ns/1ps

module config_regs import systolic_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  reg_addr_t  reg_addr,
    input  logic [7:0] reg_wdata,
    input  logic       reg_wr,
    input  logic       reg_rd,
    output logic [7:0] reg_rdata,
    cfg_if.regs        cfg
);

    logic go_req;

    // host asks for a start
    assign go_req = reg_wr && (reg_addr == REG_CTRL) && reg_wdata[0];

    // configuration bytes, written at the edge with reg_wr
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.a_base <= '0;
            cfg.b_base <= '0;
            cfg.c_base <= '0;
            cfg.k_len  <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                REG_A_BASE: cfg.a_base <= reg_wdata;
                REG_B_BASE: cfg.b_base <= reg_wdata;
                REG_C_BASE: cfg.c_base <= reg_wdata;
                REG_K_LEN:  cfg.k_len  <= reg_wdata;
                // ctrl is a strobe, status is read only
                default: ;
            endcase
        end
    end

    // go only for a real job and an idle engine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.go   <= 1'b0;
            cfg.done <= 1'b0;
        end else begin
            cfg.go <= go_req && (cfg.k_len != '0) && !cfg.busy;
            // done drops at start, rises with the last acknowledged write
            if (cfg.go) begin
                cfg.done <= 1'b0;
            end else if (cfg.finish) begin
                cfg.done <= 1'b1;
            end
        end
    end

    // read data one cycle after reg_rd
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            case (reg_addr)
                REG_A_BASE: reg_rdata <= cfg.a_base;
                REG_B_BASE: reg_rdata <= cfg.b_base;
                REG_C_BASE: reg_rdata <= cfg.c_base;
                REG_K_LEN:  reg_rdata <= cfg.k_len;
                REG_STATUS: reg_rdata <= {6'b0, cfg.busy, cfg.done};
                // ctrl and unused indexes
                default:    reg_rdata <= '0;
            endcase
        end
    end

    // controller must have left IDLE before another start can appear
    a_go_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cfg.go) |-> !cfg.busy);

endmodule

// File: design/pe.sv
`timescale 1ns/1ps

module pe import systolic_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clr,
    input  data_t a_in,
    input  logic  a_vld_in,
    input  data_t b_in,
    input  logic  b_vld_in,
    output data_t a_out,
    output logic  a_vld_out,
    output data_t b_out,
    output logic  b_vld_out,
    output acc_t  acc
);

    // valids and accumulator, clr flushes whatever is in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_vld_out <= 1'b0;
            b_vld_out <= 1'b0;
            acc       <= '0;
        end else if (clr) begin
            a_vld_out <= 1'b0;
            b_vld_out <= 1'b0;
            acc       <= '0;
        end else begin
            a_vld_out <= a_vld_in;
            b_vld_out <= b_vld_in;
            // signed 8x8 product, sign extended into the 32-bit sum
            if (a_vld_in && b_vld_in) begin
                acc <= acc + a_in * b_in;
            end
        end
    end

    // a travels right, b travels down
    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
    end

    // skew chains must line up the k-th a and b at every cell
    a_vld_pair: assert property (@(posedge clk) disable iff (!rst_n)
        a_vld_in == b_vld_in);

endmodule

// File: design/pe_array.sv
`timescale 1ns/1ps

module pe_array import systolic_pkg::*; #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    feed_if.array feed
);

    // horizontal a path, column ARRAY_SIZE is the unused right edge
    data_t a_h   [ARRAY_SIZE][ARRAY_SIZE+1];
    logic  av_h  [ARRAY_SIZE][ARRAY_SIZE+1];
    // vertical b path, row ARRAY_SIZE is the unused bottom edge
    data_t b_v   [ARRAY_SIZE+1][ARRAY_SIZE];
    logic  bv_v  [ARRAY_SIZE+1][ARRAY_SIZE];
    acc_t  acc_grid [ARRAY_SIZE][ARRAY_SIZE];

    // lane i: a row i and b column i, both delayed i cycles
    for (genvar i = 0; i < ARRAY_SIZE; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign a_h[0][0]  = feed.a_col[0];
            assign b_v[0][0]  = feed.b_row[0];
            assign av_h[0][0] = feed.feed;
            assign bv_v[0][0] = feed.feed;
        end else begin : g_skew
            data_t [i-1:0] a_sr;
            data_t [i-1:0] b_sr;
            logic  [i-1:0] v_sr;

            // operand stages, cleared with the accumulators
            always_ff @(posedge clk) begin
                if (feed.clr) begin
                    a_sr <= '0;
                    b_sr <= '0;
                end else begin
                    a_sr[0] <= feed.a_col[i];
                    b_sr[0] <= feed.b_row[i];
                    for (int j = 1; j < i; j++) begin
                        a_sr[j] <= a_sr[j-1];
                        b_sr[j] <= b_sr[j-1];
                    end
                end
            end

            // one valid chain serves both a and b of this lane
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    v_sr <= '0;
                end else begin
                    v_sr[0] <= feed.feed && !feed.clr;
                    for (int j = 1; j < i; j++) begin
                        v_sr[j] <= v_sr[j-1] && !feed.clr;
                    end
                end
            end

            assign a_h[i][0]  = a_sr[i-1];
            assign b_v[0][i]  = b_sr[i-1];
            assign av_h[i][0] = v_sr[i-1];
            assign bv_v[0][i] = v_sr[i-1];
        end
    end

    // cell (r, c) sees pair k r+c cycles after its feed
    for (genvar r = 0; r < ARRAY_SIZE; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_SIZE; c++) begin : g_col
            pe i_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .clr       (feed.clr),
                .a_in      (a_h[r][c]),
                .a_vld_in  (av_h[r][c]),
                .b_in      (b_v[r][c]),
                .b_vld_in  (bv_v[r][c]),
                .a_out     (a_h[r][c+1]),
                .a_vld_out (av_h[r][c+1]),
                .b_out     (b_v[r+1][c]),
                .b_vld_out (bv_v[r+1][c]),
                .acc       (acc_grid[r][c])
            );
        end
    end

    // read-out mux for write-back
    assign feed.result = acc_grid[feed.sel_row][feed.sel_col];

endmodule

// File: design/systolic_controller.sv
`timescale 1ns/1ps

module systolic_controller import systolic_pkg::*; #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   rd,
    output addr_t                  input_rd_addr,
    output addr_t                  weight_rd_addr,
    input  logic                   data_rdy_in,
    input  data_t [ARRAY_SIZE-1:0] input_data,
    input  data_t [ARRAY_SIZE-1:0] weight_data,
    output logic                   wr,
    output addr_t                  output_wr_addr,
    output acc_t                   data_out,
    input  logic                   data_written,
    cfg_if.ctrl                    cfg,
    feed_if.ctrl                   feed
);

    localparam int SEL_W   = sel_width(ARRAY_SIZE);
    localparam int DRAIN_W = $clog2(2 * ARRAY_SIZE);
    localparam logic [SEL_W-1:0]   SEL_LAST   = SEL_W'(ARRAY_SIZE - 1);
    // drain spans 2*ARRAY_SIZE-1 cycles, counted from zero
    localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(2 * ARRAY_SIZE - 2);

    ctrl_state_t        state;
    // pairs returned so far in this run
    addr_t              k_cnt;
    logic               rd_pend;
    logic [DRAIN_W-1:0] drain_cnt;
    logic               last_result;

    assign last_result = (feed.sel_row == SEL_LAST) && (feed.sel_col == SEL_LAST);
    assign cfg.busy    = (state != IDLE);
    // last write acknowledged
    assign cfg.finish  = (state == WRITE_BACK) && data_written && last_result;
    assign data_out    = feed.result;

    // result address follows the selects, row-major from c_base
    always_comb begin
        output_wr_addr = cfg.c_addr(feed.sel_row, feed.sel_col);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            rd             <= 1'b0;
            rd_pend        <= 1'b0;
            input_rd_addr  <= '0;
            weight_rd_addr <= '0;
            k_cnt          <= '0;
            drain_cnt      <= '0;
            wr             <= 1'b0;
            feed.clr       <= 1'b0;
            feed.feed      <= 1'b0;
            feed.sel_row   <= '0;
            feed.sel_col   <= '0;
        end else begin
            // strobes default low
            rd        <= 1'b0;
            feed.clr  <= 1'b0;
            feed.feed <= 1'b0;
            case (state)
                IDLE: begin
                    // clear the grid and issue the first fetch together
                    if (cfg.go) begin
                        state          <= FILL;
                        feed.clr       <= 1'b1;
                        k_cnt          <= '0;
                        rd             <= 1'b1;
                        rd_pend        <= 1'b1;
                        input_rd_addr  <= cfg.a_base;
                        weight_rd_addr <= cfg.b_base;
                    end
                end
                FILL: begin
                    // returned pair goes into the grid next cycle
                    if (data_rdy_in) begin
                        feed.feed <= 1'b1;
                        rd_pend   <= 1'b0;
                        k_cnt     <= k_cnt + 1'b1;
                    end
                    // after each feed either fetch again or start draining
                    if (feed.feed) begin
                        if (k_cnt == cfg.k_len) begin
                            state     <= COMPUTING;
                            drain_cnt <= '0;
                        end else begin
                            rd             <= 1'b1;
                            rd_pend        <= 1'b1;
                            input_rd_addr  <= cfg.a_base + k_cnt;
                            weight_rd_addr <= cfg.b_base + k_cnt;
                        end
                    end
                end
                COMPUTING: begin
                    if (drain_cnt == DRAIN_LAST) begin
                        state        <= WRITE_BACK;
                        wr           <= 1'b1;
                        feed.sel_row <= '0;
                        feed.sel_col <= '0;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                WRITE_BACK: begin
                    // hold address and data until acknowledged
                    if (data_written) begin
                        if (last_result) begin
                            wr    <= 1'b0;
                            state <= IDLE;
                        end else if (feed.sel_col == SEL_LAST) begin
                            feed.sel_col <= '0;
                            feed.sel_row <= feed.sel_row + 1'b1;
                        end else begin
                            feed.sel_col <= feed.sel_col + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // operand capture, one feed per returned read
    always_ff @(posedge clk) begin
        if ((state == FILL) && data_rdy_in) begin
            feed.a_col <= input_data;
            feed.b_row <= weight_data;
        end
    end

    // memory is never read and written in the same cycle
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd && wr));

    // responder answers only an outstanding read
    a_rdy_pending: assert property (@(posedge clk) disable iff (!rst_n)
        data_rdy_in |-> rd_pend);

endmodule

// File: design/systolic_accel.sv
`timescale 1ns/1ps

module systolic_accel import systolic_pkg::*; #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // host register bus
    input  reg_addr_t              reg_addr,
    input  logic [7:0]             reg_wdata,
    input  logic                   reg_wr,
    input  logic                   reg_rd,
    output logic [7:0]             reg_rdata,
    // operand fetch
    output logic                   rd,
    output addr_t                  input_rd_addr,
    output addr_t                  weight_rd_addr,
    input  logic                   data_rdy_in,
    input  data_t [ARRAY_SIZE-1:0] input_data,
    input  data_t [ARRAY_SIZE-1:0] weight_data,
    // result write
    output logic                   wr,
    output addr_t                  output_wr_addr,
    output acc_t                   data_out,
    input  logic                   data_written,
    // status
    output logic                   busy,
    output logic                   done
);

    cfg_if  #(.ARRAY_SIZE(ARRAY_SIZE)) cfg_bus ();
    feed_if #(.ARRAY_SIZE(ARRAY_SIZE)) feed_bus ();

    config_regs i_config_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_rdata (reg_rdata),
        .cfg       (cfg_bus.regs)
    );

    systolic_controller #(.ARRAY_SIZE(ARRAY_SIZE)) i_systolic_controller (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd             (rd),
        .input_rd_addr  (input_rd_addr),
        .weight_rd_addr (weight_rd_addr),
        .data_rdy_in    (data_rdy_in),
        .input_data     (input_data),
        .weight_data    (weight_data),
        .wr             (wr),
        .output_wr_addr (output_wr_addr),
        .data_out       (data_out),
        .data_written   (data_written),
        .cfg            (cfg_bus.ctrl),
        .feed           (feed_bus.ctrl)
    );

    pe_array #(.ARRAY_SIZE(ARRAY_SIZE)) i_pe_array (
        .clk   (clk),
        .rst_n (rst_n),
        .feed  (feed_bus.array)
    );

    // status bits as the register file reports them
    assign busy = cfg_bus.busy;
    assign done = cfg_bus.done;

endmodule

// File: test/tb_systolic_accel.sv
`timescale 1ns/1ps

module tb_systolic_accel import systolic_pkg::*; ();

    localparam int N = 4;
    // five tests stay under about 1000 cycles, this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 6000;

    logic                clk = 1'b0;
    logic                rst_n;
    reg_addr_t           reg_addr;
    logic [7:0]          reg_wdata;
    logic                reg_wr;
    logic                reg_rd;
    logic [7:0]          reg_rdata;
    logic                rd;
    addr_t               input_rd_addr;
    addr_t               weight_rd_addr;
    logic                data_rdy_in;
    logic [N*8-1:0]      input_data;
    logic [N*8-1:0]      weight_data;
    logic                wr;
    addr_t               output_wr_addr;
    acc_t                data_out;
    logic                data_written;
    logic                busy;
    logic                done;

    // operand words hold one byte lane per row or column
    logic [N*8-1:0]      in_mem  [256];
    logic [N*8-1:0]      wt_mem  [256];
    acc_t                res_mem [256];

    // job of the current run
    addr_t               cur_a;
    addr_t               cur_b;
    addr_t               cur_c;
    addr_t               cur_k;
    // 0 draws a random read latency
    int                  rd_delay;
    // -1 draws a random write acknowledge delay
    int                  wr_delay;
    int                  rd_count;
    int                  wr_count;
    int                  errors = 0;
    int                  tests_passed = 0;
    int                  tests_failed = 0;
    int                  cycles = 0;
    logic [15:0]         lfsr_state = 16'd56355;

    systolic_accel #(.ARRAY_SIZE(N)) i_systolic_accel (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_rdata      (reg_rdata),
        .rd             (rd),
        .input_rd_addr  (input_rd_addr),
        .weight_rd_addr (weight_rd_addr),
        .data_rdy_in    (data_rdy_in),
        .input_data     (input_data),
        .weight_data    (weight_data),
        .wr             (wr),
        .output_wr_addr (output_wr_addr),
        .data_out       (data_out),
        .data_written   (data_written),
        .busy           (busy),
        .done           (done)
    );

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected 'h%0h, got 'h%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic expect_write_held(input addr_t wa, input acc_t wd);
        check("wr", 1'b1, wr);
        check("output_wr_addr", wa, output_wr_addr);
        check("data_out", wd, data_out);
    endtask

    // read responder, one outstanding fetch
    initial begin
        addr_t       ia;
        addr_t       wa;
        int unsigned d;
        data_rdy_in = 1'b0;
        input_data  = '0;
        weight_data = '0;
        forever begin
            @(posedge clk);
            if (rd) begin
                ia = input_rd_addr;
                wa = weight_rd_addr;
                check("input_rd_addr", addr_t'(cur_a + rd_count), ia);
                check("weight_rd_addr", addr_t'(cur_b + rd_count), wa);
                rd_count++;
                if (rd_delay > 0) begin
                    d = rd_delay;
                end else begin
                    random_bits(2, d);
                    d = d + 1;
                end
                // rd is a one-cycle strobe and stays low while this read is open
                repeat (d - 1) begin
                    @(posedge clk);
                    check("rd", 1'b0, rd);
                end
                data_rdy_in <= 1'b1;
                input_data  <= in_mem[ia];
                weight_data <= wt_mem[wa];
                @(posedge clk);
                check("rd", 1'b0, rd);
                data_rdy_in <= 1'b0;
            end
        end
    end

    // write responder, checks that each write is held until acknowledged
    initial begin
        addr_t       wa;
        acc_t        wd;
        int unsigned d;
        data_written = 1'b0;
        forever begin
            @(posedge clk);
            if (wr) begin
                wa = output_wr_addr;
                wd = data_out;
                // row-major order from c_base
                check("output_wr_addr", addr_t'(cur_c + wr_count), wa);
                if (wr_delay >= 0) begin
                    d = wr_delay;
                end else begin
                    random_bits(3, d);
                    d = d % 5;
                end
                repeat (d) begin
                    @(posedge clk);
                    expect_write_held(wa, wd);
                end
                data_written <= 1'b1;
                // the DUT takes the acknowledge at this edge
                @(posedge clk);
                expect_write_held(wa, wd);
                data_written <= 1'b0;
                res_mem[wa] = wd;
                wr_count++;
            end
        end
    end

    task automatic reg_write(input reg_addr_t a, input logic [7:0] v);
        @(posedge clk);
        reg_addr  <= a;
        reg_wdata <= v;
        reg_wr    <= 1'b1;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    // data is registered at the edge after reg_rd
    task automatic reg_read(input reg_addr_t a, output logic [7:0] v);
        @(posedge clk);
        reg_addr <= a;
        reg_rd   <= 1'b1;
        @(posedge clk);
        reg_rd   <= 1'b0;
        @(posedge clk);
        v = reg_rdata;
    endtask

    task automatic configure(input addr_t a, input addr_t b, input addr_t c, input addr_t k);
        reg_write(REG_A_BASE, a);
        reg_write(REG_B_BASE, b);
        reg_write(REG_C_BASE, c);
        reg_write(REG_K_LEN, k);
        cur_a = a;
        cur_b = b;
        cur_c = c;
        cur_k = k;
    endtask

    // every lane pattern is a function of the full word address
    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            for (int l = 0; l < N; l++) begin
                in_mem[i][l*8 +: 8] = 8'(i) ^ 8'(l * 37);
                wt_mem[i][l*8 +: 8] = ~(8'(i) ^ 8'(l * 91));
            end
            res_mem[i] = 32'hC0DE_0000 | 32'(i);
        end
    endtask

    task automatic random_operands(input addr_t a, input addr_t b, input int k);
        int unsigned v;
        for (int kk = 0; kk < k; kk++) begin
            for (int l = 0; l < N; l++) begin
                random_bits(8, v);
                in_mem[addr_t'(a + kk)][l*8 +: 8] = 8'(v);
                random_bits(8, v);
                wt_mem[addr_t'(b + kk)][l*8 +: 8] = 8'(v);
            end
        end
    endtask

    // C[r][c] = sum over k of A[r][k] * B[k][c], signed
    function automatic acc_t ref_entry(input int r, input int c);
        acc_t  sum;
        data_t x;
        data_t y;
        sum = '0;
        for (int k = 0; k < cur_k; k++) begin
            x = in_mem[addr_t'(cur_a + k)][r*8 +: 8];
            y = wt_mem[addr_t'(cur_b + k)][c*8 +: 8];
            sum += acc_t'(x) * acc_t'(y);
        end
        return sum;
    endfunction

    task automatic check_results();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                check($sformatf("C[%0d][%0d]", r, c), ref_entry(r, c),
                      res_mem[addr_t'(cur_c + r * N + c)]);
            end
        end
        check("write count", N * N, wr_count);
        check("read count", cur_k, rd_count);
    endtask

    // start a run, optionally poke go again while busy, wait for done
    task automatic run_and_wait(input bit go_while_busy);
        int waited;
        rd_count = 0;
        wr_count = 0;
        reg_write(REG_CTRL, 8'h01);
        waited = 0;
        while (!busy && waited < 8) begin
            @(posedge clk);
            waited++;
        end
        if (!busy) begin
            $display("Error at %0t: engine did not turn busy after go", $time);
            errors++;
        end else begin
            // done drops with the start
            check("done at start", 1'b0, done);
            if (go_while_busy) begin
                reg_write(REG_CTRL, 8'h01);
            end
            while (!done) begin
                @(posedge clk);
                if (!busy && !done) begin
                    $display("Error at %0t: busy dropped before done", $time);
                    errors++;
                    break;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    task automatic registers_readback();
        int         e0;
        logic [7:0] v;
        logic [7:0] pat [4];
        e0 = errors;
        pat = '{8'h5A, 8'hC3, 8'h96, 8'h3C};
        reg_read(REG_STATUS, v);
        check("status after reset", 8'h00, v);
        // strobes and status pins idle out of reset
        check("rd after reset", 1'b0, rd);
        check("wr after reset", 1'b0, wr);
        check("busy after reset", 1'b0, busy);
        check("done after reset", 1'b0, done);
        for (int i = 0; i < 4; i++) begin
            reg_write(reg_addr_t'(i), pat[i]);
        end
        for (int i = 0; i < 4; i++) begin
            reg_read(reg_addr_t'(i), v);
            check($sformatf("reg %0d", i), pat[i], v);
        end
        reg_read(3'd5, v);
        check("reg 5", 8'h00, v);
        reg_read(3'd6, v);
        check("reg 6", 8'h00, v);
        // zero k_len keeps this go from starting a run
        reg_write(REG_K_LEN, 8'h00);
        reg_write(REG_CTRL, 8'h01);
        reg_read(REG_CTRL, v);
        check("ctrl readback", 8'h00, v);
        reg_read(REG_STATUS, v);
        check("status after gated go", 8'h00, v);
        report_test("register readback", e0);
    endtask

    task automatic identity_product();
        int         e0;
        logic [7:0] v;
        e0 = errors;
        rd_delay = 1;
        wr_delay = 0;
        configure(8'h10, 8'h20, 8'h40, N);
        random_operands(8'h10, 8'h20, N);
        for (int k = 0; k < N; k++) begin
            for (int l = 0; l < N; l++) begin
                in_mem[8'h10 + k][l*8 +: 8] = (l == k) ? 8'd1 : 8'd0;
            end
        end
        run_and_wait(1'b0);
        // identity A gives C equal to B
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                check($sformatf("C[%0d][%0d]", r, c),
                      acc_t'(data_t'(wt_mem[8'h20 + r][c*8 +: 8])),
                      res_mem[8'h40 + r * N + c]);
            end
        end
        check("write count", N * N, wr_count);
        reg_read(REG_STATUS, v);
        check("status after run", 8'h01, v);
        report_test("identity product", e0);
    endtask

    task automatic random_product();
        int e0;
        e0 = errors;
        rd_delay = 0;
        wr_delay = 0;
        configure(8'h30, 8'h50, 8'h80, 8'd6);
        random_operands(8'h30, 8'h50, 6);
        // at least one large negative product
        in_mem[8'h30][7:0] = 8'h80;
        wt_mem[8'h50][7:0] = 8'h7F;
        run_and_wait(1'b0);
        check_results();
        report_test("random signed product", e0);
    endtask

    task automatic write_backpressure();
        int e0;
        e0 = errors;
        rd_delay = 0;
        wr_delay = -1;
        configure(8'h38, 8'h58, 8'hC0, 8'd5);
        random_operands(8'h38, 8'h58, 5);
        run_and_wait(1'b0);
        check_results();
        report_test("write backpressure", e0);
    endtask

    task automatic busy_go_and_restart();
        int         e0;
        logic [7:0] v;
        e0 = errors;
        rd_delay = 0;
        wr_delay = -1;
        configure(8'h00, 8'h08, 8'h90, 8'd7);
        random_operands(8'h00, 8'h08, 7);
        run_and_wait(1'b1);
        repeat (4) @(posedge clk);
        // the extra go must not have queued a second run
        check("busy after run", 1'b0, busy);
        check_results();
        configure(8'h60, 8'h70, 8'hB0, 8'd3);
        random_operands(8'h60, 8'h70, 3);
        run_and_wait(1'b0);
        check_results();
        reg_read(REG_STATUS, v);
        check("status after second run", 8'h01, v);
        report_test("busy go and restart", e0);
    endtask

    initial begin
        rst_n     = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        rd_delay  = 1;
        wr_delay  = 0;
        cur_a     = '0;
        cur_b     = '0;
        cur_c     = '0;
        cur_k     = '0;
        rd_count  = 0;
        wr_count  = 0;
        fill_memories();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        registers_readback();
        identity_product();
        random_product();
        write_backpressure();
        busy_go_and_restart();
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: systolic_accel.f
design/systolic_pkg.sv
design/systolic_if.sv
design/config_regs.sv
design/pe.sv
design/pe_array.sv
design/systolic_controller.sv
design/systolic_accel.sv
test/tb_systolic_accel.sv

// File: Bender.yml
package:
  name: systolic_accel

sources:
  - design/systolic_pkg.sv
  - design/systolic_if.sv
  - design/config_regs.sv
  - design/pe.sv
  - design/pe_array.sv
  - design/systolic_controller.sv
  - design/systolic_accel.sv
  - target: test
    files:
      - test/tb_systolic_accel.sv
